//--- logic/bus_pkg.sv
package bus_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BEAT_W = 64;
  localparam int STRB_W = BEAT_W / 8;

  typedef logic [2:0] size_t;  // axi arsize/awsize

  localparam size_t SIZE_B = 3'd0;
  localparam size_t SIZE_H = 3'd1;
  localparam size_t SIZE_W = 3'd2;

  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY = 2'b00;

  // one data beat, whole or as two words indexed by addr[2]
  typedef union packed {
    logic [BEAT_W-1:0]      dword;
    logic [1:0][DATA_W-1:0] word;
  } beat_u;

endpackage

//--- logic/map_pkg.sv
package map_pkg;

  // clint block and the mtime register inside it
  localparam logic [bus_pkg::ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
  localparam logic [bus_pkg::ADDR_W-1:0] MTIME_OFF  = 32'h0000_bff8;

  localparam logic [bus_pkg::ADDR_W-1:0] RTC_ADDR_LO = CLINT_BASE + MTIME_OFF;
  localparam logic [bus_pkg::ADDR_W-1:0] RTC_ADDR_HI = RTC_ADDR_LO + 32'd4;  // upper word

endpackage

//--- logic/clint_if.sv
`timescale 1ns/1ps

interface clint_if;
  logic                       req;     // single cycle
  logic                       hi_sel;  // upper word of mtime
  logic [bus_pkg::DATA_W-1:0] rdata;
  logic                       rvalid;  // one cycle after req

  modport arb (
    output req,
    output hi_sel,
    input  rdata,
    input  rvalid
  );

  modport timer (
    input  req,
    input  hi_sel,
    output rdata,
    output rvalid
  );
endinterface

//--- logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ifu_arvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0] ifu_araddr_i,
  input  logic                       lsu_arvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0] lsu_araddr_i,
  input  logic                       lsu_awvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0] lsu_awaddr_i,
  input  logic                       m_arready_i,
  input  logic                       m_rvalid_i,
  input  logic                       m_awready_i,
  input  logic                       m_wready_i,
  input  logic                       m_bvalid_i,
  output logic                       m_arvalid_o,
  output logic                       m_awvalid_o,
  output logic                       m_wvalid_o,
  output logic                       m_rready_o,
  output logic                       m_bready_o,
  output logic                       grant_lsu_o,
  output logic [bus_pkg::ADDR_W-1:0] req_addr_o,
  output logic                       ifu_rvalid_o,
  output logic                       lsu_rvalid_o,
  output logic                       lsu_wdone_o,
  clint_if.arb                       clint
);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_RDATA = 2'd1;
  localparam logic [1:0] S_WRESP = 2'd2;
  localparam logic [1:0] S_TWAIT = 2'd3;

  logic [1:0] state_q;
  logic       lock_q;     // grant_q owns the bus
  logic       grant_q;
  logic       aw_done_q;
  logic       w_done_q;

  logic       idle;
  logic       rtc_hit;
  logic       lsu_wr;
  logic       timer_go;
  logic       ar_acc;
  logic       aw_acc;
  logic       w_acc;

  assign idle    = (state_q == S_IDLE);
  assign rtc_hit = (lsu_araddr_i == map_pkg::RTC_ADDR_LO) ||
                   (lsu_araddr_i == map_pkg::RTC_ADDR_HI);

  // lsu wins unless a transfer has already started
  assign grant_lsu_o = lock_q ? grant_q : (lsu_arvalid_i || lsu_awvalid_i);
  assign lsu_wr      = grant_lsu_o && lsu_awvalid_i;
  assign req_addr_o  = !grant_lsu_o  ? ifu_araddr_i :
                       lsu_awvalid_i ? lsu_awaddr_i : lsu_araddr_i;

  assign timer_go    = idle && grant_lsu_o && lsu_arvalid_i && rtc_hit;
  assign m_arvalid_o = idle && (grant_lsu_o ? (lsu_arvalid_i && !rtc_hit) : ifu_arvalid_i);
  assign m_awvalid_o = idle && lsu_wr && !aw_done_q;
  assign m_wvalid_o  = idle && lsu_wr && !w_done_q;
  assign m_rready_o  = (state_q == S_RDATA);
  assign m_bready_o  = (state_q == S_WRESP);

  assign ar_acc = m_arvalid_o && m_arready_i;
  assign aw_acc = aw_done_q || (m_awvalid_o && m_awready_i);
  assign w_acc  = w_done_q || (m_wvalid_o && m_wready_i);

  assign ifu_rvalid_o = m_rready_o && m_rvalid_i && !grant_q;
  assign lsu_rvalid_o = (m_rready_o && m_rvalid_i && grant_q) ||
                        ((state_q == S_TWAIT) && clint.rvalid);
  assign lsu_wdone_o  = m_bready_o && m_bvalid_i;

  // lsu holds its address through the timer wait
  assign clint.hi_sel = (lsu_araddr_i == map_pkg::RTC_ADDR_HI);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= S_IDLE;
      lock_q    <= 1'b0;
      grant_q   <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      clint.req <= 1'b0;
    end
    else
    begin
      clint.req <= timer_go;
      case (state_q)
        S_IDLE:
        begin
          grant_q <= grant_lsu_o;
          lock_q  <= m_arvalid_o || m_awvalid_o || m_wvalid_o || timer_go;
          if (timer_go)
          begin
            state_q <= S_TWAIT;
          end
          else if (ar_acc)
          begin
            state_q <= S_RDATA;
          end
          else if (lsu_wr && aw_acc && w_acc)
          begin
            state_q   <= S_WRESP;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end
          else if (lsu_wr)
          begin
            aw_done_q <= aw_acc;  // one channel may lag the other
            w_done_q  <= w_acc;
          end
        end
        S_RDATA:
        begin
          if (m_rvalid_i)
          begin
            state_q <= S_IDLE;
            lock_q  <= 1'b0;
          end
        end
        S_WRESP:
        begin
          if (m_bvalid_i)
          begin
            state_q <= S_IDLE;
            lock_q  <= 1'b0;
          end
        end
        default:
        begin
          if (clint.rvalid)
          begin
            state_q <= S_IDLE;
            lock_q  <= 1'b0;
          end
        end
      endcase
    end
  end

endmodule

//--- logic/lane_align.sv
`timescale 1ns/1ps

module lane_align (
  input  logic                         grant_lsu_i,
  input  logic [bus_pkg::ADDR_W-1:0]   req_addr_i,
  input  logic [bus_pkg::DATA_W/8-1:0] lsu_rstrb_i,
  input  logic [bus_pkg::DATA_W/8-1:0] lsu_wstrb_i,
  input  logic [bus_pkg::DATA_W-1:0]   lsu_wdata_i,
  input  bus_pkg::beat_u               m_rdata_i,
  input  logic [bus_pkg::DATA_W-1:0]   clint_rdata_i,
  input  logic                         clint_sel_i,
  output logic [bus_pkg::ADDR_W-1:0]   m_araddr_o,
  output logic [bus_pkg::ADDR_W-1:0]   m_awaddr_o,
  output bus_pkg::size_t               m_arsize_o,
  output bus_pkg::size_t               m_awsize_o,
  output bus_pkg::beat_u               m_wdata_o,
  output logic [bus_pkg::STRB_W-1:0]   m_wstrb_o,
  output logic [bus_pkg::DATA_W-1:0]   rdata_o
);

  logic [1:0]                   byte_off;
  logic [bus_pkg::DATA_W-1:0]   wword;
  logic [bus_pkg::DATA_W/8-1:0] wstrb_sh;

  function automatic bus_pkg::size_t strb_size(
    input logic [bus_pkg::DATA_W/8-1:0] strb
  );
    case (strb)
      4'h1:    strb_size = bus_pkg::SIZE_B;
      4'h3:    strb_size = bus_pkg::SIZE_H;
      default: strb_size = bus_pkg::SIZE_W;
    endcase
  endfunction

  assign byte_off   = req_addr_i[1:0];
  assign m_araddr_o = req_addr_i;
  assign m_awaddr_o = req_addr_i;

  assign m_arsize_o = grant_lsu_i ? strb_size(lsu_rstrb_i) : bus_pkg::SIZE_W;  // fetch is a word
  assign m_awsize_o = strb_size(lsu_wstrb_i);

  assign wword          = lsu_wdata_i << {byte_off, 3'b000};
  assign wstrb_sh       = lsu_wstrb_i << byte_off;
  assign m_wdata_o.word = {wword, wword};  // slave picks the half via wstrb

  always_comb
  begin
    m_wstrb_o = '0;
    m_wstrb_o[{req_addr_i[2], 2'b00} +: bus_pkg::DATA_W/8] = wstrb_sh;
  end

  // timer word overrides the bus beat
  assign rdata_o = clint_sel_i ? clint_rdata_i : m_rdata_i.word[req_addr_i[2]];

endmodule

//--- logic/clint_timer.sv
`timescale 1ns/1ps

module clint_timer (
  input  logic   clk,
  input  logic   rst,
  clint_if.timer bus
);

  bus_pkg::beat_u mtime;  // free running

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime.dword <= '0;
      bus.rvalid  <= 1'b0;
    end
    else
    begin
      mtime.dword <= mtime.dword + 1'b1;
      bus.rvalid  <= bus.req;
    end
  end

  // value as seen in the req cycle
  always_ff @(posedge clk)
  begin
    if (bus.req)
    begin
      bus.rdata <= mtime.word[bus.hi_sel];
    end
  end

endmodule

//--- logic/core_bus_top.sv
`timescale 1ns/1ps

module core_bus_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         ifu_arvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0]   ifu_araddr_i,
  output logic                         ifu_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0]   ifu_rdata_o,
  input  logic                         lsu_arvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0]   lsu_araddr_i,
  input  logic [bus_pkg::DATA_W/8-1:0] lsu_rstrb_i,
  output logic                         lsu_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0]   lsu_rdata_o,
  input  logic                         lsu_awvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0]   lsu_awaddr_i,
  input  logic [bus_pkg::DATA_W-1:0]   lsu_wdata_i,
  input  logic [bus_pkg::DATA_W/8-1:0] lsu_wstrb_i,
  output logic                         lsu_wdone_o,
  output logic [bus_pkg::ADDR_W-1:0]   m_araddr_o,
  output bus_pkg::size_t               m_arsize_o,
  output logic                         m_arvalid_o,
  input  logic                         m_arready_i,
  input  logic [bus_pkg::BEAT_W-1:0]   m_rdata_i,
  input  bus_pkg::resp_t               m_rresp_i,
  input  logic                         m_rvalid_i,
  output logic                         m_rready_o,
  output logic [bus_pkg::ADDR_W-1:0]   m_awaddr_o,
  output bus_pkg::size_t               m_awsize_o,
  output logic                         m_awvalid_o,
  input  logic                         m_awready_i,
  output logic [bus_pkg::BEAT_W-1:0]   m_wdata_o,
  output logic [bus_pkg::STRB_W-1:0]   m_wstrb_o,
  output logic                         m_wvalid_o,
  input  logic                         m_wready_i,
  input  bus_pkg::resp_t               m_bresp_i,
  input  logic                         m_bvalid_i,
  output logic                         m_bready_o
);

  logic                       grant_lsu;
  logic [bus_pkg::ADDR_W-1:0] req_addr;
  logic [bus_pkg::DATA_W-1:0] rdata;

  clint_if clint_bus ();

  bus_arbiter u_bus_arbiter (
    .clk           (clk),
    .rst           (rst),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_araddr_i  (ifu_araddr_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_awvalid_i (lsu_awvalid_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .m_arready_i   (m_arready_i),
    .m_rvalid_i    (m_rvalid_i),
    .m_awready_i   (m_awready_i),
    .m_wready_i    (m_wready_i),
    .m_bvalid_i    (m_bvalid_i),
    .m_arvalid_o   (m_arvalid_o),
    .m_awvalid_o   (m_awvalid_o),
    .m_wvalid_o    (m_wvalid_o),
    .m_rready_o    (m_rready_o),
    .m_bready_o    (m_bready_o),
    .grant_lsu_o   (grant_lsu),
    .req_addr_o    (req_addr),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_wdone_o   (lsu_wdone_o),
    .clint         (clint_bus.arb)
  );

  lane_align u_lane_align (
    .grant_lsu_i   (grant_lsu),
    .req_addr_i    (req_addr),
    .lsu_rstrb_i   (lsu_rstrb_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .m_rdata_i     (m_rdata_i),
    .clint_rdata_i (clint_bus.rdata),
    .clint_sel_i   (clint_bus.rvalid),  // only high in the timer response cycle
    .m_araddr_o    (m_araddr_o),
    .m_awaddr_o    (m_awaddr_o),
    .m_arsize_o    (m_arsize_o),
    .m_awsize_o    (m_awsize_o),
    .m_wdata_o     (m_wdata_o),
    .m_wstrb_o     (m_wstrb_o),
    .rdata_o       (rdata)
  );

  clint_timer u_clint_timer (
    .clk (clk),
    .rst (rst),
    .bus (clint_bus.timer)
  );

  // one word path, qualified by each client's own pulse
  assign ifu_rdata_o = rdata;
  assign lsu_rdata_o = rdata;

endmodule

//--- verif/core_bus_chk.sv
`timescale 1ns/1ps

module core_bus_chk (
  input logic                       clk,
  input logic                       rst,
  input logic                       m_arvalid_o,
  input logic                       m_arready_i,
  input logic [bus_pkg::ADDR_W-1:0] m_araddr_o,
  input logic                       m_awvalid_o,
  input logic                       m_awready_i,
  input logic [bus_pkg::ADDR_W-1:0] m_awaddr_o,
  input logic                       m_wvalid_o,
  input logic                       m_wready_i,
  input logic                       m_rvalid_i,
  input bus_pkg::resp_t             m_rresp_i,
  input logic                       m_bvalid_i,
  input bus_pkg::resp_t             m_bresp_i,
  input logic                       ifu_rvalid_o,
  input logic                       lsu_rvalid_o
);

  ar_hold: assert property (@(posedge clk) disable iff (rst)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o))
    else $error("arvalid dropped or araddr moved before arready");

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    m_awvalid_o && !m_awready_i |=> m_awvalid_o && $stable(m_awaddr_o))
    else $error("awvalid dropped or awaddr moved before awready");

  w_hold: assert property (@(posedge clk) disable iff (rst)
    m_wvalid_o && !m_wready_i |=> m_wvalid_o)
    else $error("wvalid dropped before wready");

  rresp_ok: assert property (@(posedge clk) disable iff (rst)
    m_rvalid_i |-> m_rresp_i == bus_pkg::RESP_OKAY)
    else $error("rresp not okay");

  bresp_ok: assert property (@(posedge clk) disable iff (rst)
    m_bvalid_i |-> m_bresp_i == bus_pkg::RESP_OKAY)
    else $error("bresp not okay");

  one_pulse: assert property (@(posedge clk) disable iff (rst)
    !(ifu_rvalid_o && lsu_rvalid_o))
    else $error("ifu and lsu responses in the same cycle");

endmodule

//--- verif/core_bus_tb.sv
`timescale 1ns/1ps

module core_bus_tb;

  localparam int N_TX     = 150;  // per client
  localparam int WORST_CY = 60;
  localparam int LIMIT_NS = (2 * N_TX * WORST_CY + 20) * 10;

  logic clk = 1'b0;
  logic rst;
  logic ifu_arvalid_i, lsu_arvalid_i, lsu_awvalid_i;
  logic [31:0] ifu_araddr_i, lsu_araddr_i, lsu_awaddr_i, lsu_wdata_i;
  logic [3:0] lsu_rstrb_i, lsu_wstrb_i;
  logic m_arready_i, m_rvalid_i, m_awready_i, m_wready_i, m_bvalid_i;
  logic [63:0] m_rdata_i;
  bus_pkg::resp_t m_rresp_i, m_bresp_i;
  logic ifu_rvalid_o, lsu_rvalid_o, lsu_wdone_o;
  logic [31:0] ifu_rdata_o, lsu_rdata_o, m_araddr_o, m_awaddr_o;
  bus_pkg::size_t m_arsize_o, m_awsize_o;
  logic m_arvalid_o, m_rready_o, m_awvalid_o, m_wvalid_o, m_bready_o;
  logic [63:0] m_wdata_o;
  logic [7:0] m_wstrb_o;

  integer seed = 32'h3488;
  logic [63:0] cycle_cnt;
  logic any_req;
  logic ifu_req_q;
  logic lsu_req_q;
  logic lsu_first;  // both clients rose together, lsu owed the first response
  logic [7:0] model_mem [256];  // reference bytes
  logic [63:0] slave_mem [32];
  logic [7:0] rd_addr, exp_strb;
  logic [63:0] exp_data, mask;
  bus_pkg::beat_u got_b, exp_b;
  bit rd_pend, aw_got, w_got, b_pend;
  int rd_wait, b_wait;

  core_bus_top u_core_bus_top (.*);

  bind core_bus_top core_bus_chk u_core_bus_chk (.*);

  always #5 clk = ~clk;

  task automatic stop_with_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_word(input logic [bus_pkg::DATA_W-1:0] got, exp, input string msg);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic check_beat(input bus_pkg::beat_u got, exp, input string msg);
    if (got.dword !== exp.dword)
    begin
      $display("mismatch at %0t: %s got %h expected %h", $time, msg, got.dword, exp.dword);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic check_size(input bus_pkg::size_t got, exp, input string msg);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, msg, got, exp);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  function automatic logic [7:0] fill_byte(input logic [7:0] a);
    fill_byte = (a * 8'd29) ^ 8'h6c ^ {a[2:0], a[7:3]};
  endfunction

  function automatic bus_pkg::size_t size_of(input logic [3:0] strb);
    size_of = (strb == 4'h1) ? bus_pkg::SIZE_B : (strb == 4'h3) ? bus_pkg::SIZE_H : bus_pkg::SIZE_W;
  endfunction

  function automatic logic [31:0] model_word(input logic [7:0] addr);
    logic [7:0] a;
    a = {addr[7:2], 2'b00};
    model_word = {model_mem[a + 3], model_mem[a + 2], model_mem[a + 1], model_mem[a]};
  endfunction

  always @(posedge clk)
  begin
    if (rst)
    begin
      cycle_cnt <= '0;
      any_req   <= 1'b0;
    end
    else
    begin
      cycle_cnt <= cycle_cnt + 1;  // tracks mtime
      if (ifu_arvalid_i || lsu_arvalid_i || lsu_awvalid_i)
        any_req <= 1'b1;
    end
  end

  // both clients idle the cycle before, so the arbiter is idle when they rise
  always @(posedge clk)
  begin
    if (rst)
    begin
      ifu_req_q <= 1'b0;
      lsu_req_q <= 1'b0;
      lsu_first <= 1'b0;
    end
    else
    begin
      ifu_req_q <= ifu_arvalid_i;
      lsu_req_q <= lsu_arvalid_i || lsu_awvalid_i;
      if (lsu_first && ifu_rvalid_o)
        stop_with_error("the IFU was served before the LSU after a same-cycle request");
      if (lsu_rvalid_o || lsu_wdone_o)
        lsu_first <= 1'b0;
      else if (ifu_arvalid_i && !ifu_req_q && (lsu_arvalid_i || lsu_awvalid_i) && !lsu_req_q)
        lsu_first <= 1'b1;
    end
  end

  // axi slave with random ready and response delays
  always @(posedge clk)
  begin
    if (rst)
    begin
      rd_pend = 0;
      aw_got  = 0;
      w_got   = 0;
      b_pend  = 0;
    end
    else
    begin
      if (!any_req && !(ifu_arvalid_i || lsu_arvalid_i || lsu_awvalid_i) &&
          (m_arvalid_o || m_awvalid_o || m_wvalid_o))
        stop_with_error("an AXI valid went high before any client request");
      m_arready_i <= ($random(seed) & 3) != 0;
      m_awready_i <= ($random(seed) & 3) != 0;
      m_wready_i  <= ($random(seed) & 3) != 0;
      if (m_rvalid_i && m_rready_o)
      begin
        m_rvalid_i <= 1'b0;
        rd_pend = 0;
      end
      else if (rd_pend)
      begin
        if (rd_wait == 0)
        begin
          m_rvalid_i <= 1'b1;
          m_rdata_i  <= slave_mem[rd_addr[7:3]];
        end
        else
          rd_wait--;
      end
      if (m_arvalid_o && m_arready_i)
      begin
        // lsu addresses live in the upper half, fetches in the lower
        if (m_araddr_o[7])
          check_size(m_arsize_o, size_of(lsu_rstrb_i), "lsu arsize");
        else
          check_size(m_arsize_o, bus_pkg::SIZE_W, "ifu arsize");
        rd_addr = m_araddr_o[7:0];
        rd_pend = 1;
        rd_wait = $random(seed) & 3;
      end
      if (m_awvalid_o && m_awready_i)
      begin
        check_word(m_awaddr_o, lsu_awaddr_i, "awaddr");
        check_size(m_awsize_o, size_of(lsu_wstrb_i), "awsize");
        aw_got = 1;
      end
      if (m_wvalid_o && m_wready_i)
      begin
        exp_strb = {4'h0, lsu_wstrb_i} << lsu_awaddr_i[2:0];
        exp_data = {32'h0, lsu_wdata_i} << {lsu_awaddr_i[2:0], 3'b000};
        for (int j = 0; j < 8; j++)
          mask[8*j +: 8] = {8{exp_strb[j]}};
        check_word({24'h0, m_wstrb_o}, {24'h0, exp_strb}, "wstrb");
        got_b.dword = m_wdata_o & mask;
        exp_b.dword = exp_data & mask;
        check_beat(got_b, exp_b, "wdata lanes");
        slave_mem[lsu_awaddr_i[7:3]] = (slave_mem[lsu_awaddr_i[7:3]] & ~mask) | got_b.dword;
        w_got = 1;
      end
      if (m_bvalid_i && m_bready_o)
      begin
        m_bvalid_i <= 1'b0;
        b_pend = 0;
      end
      else if (b_pend)
      begin
        if (b_wait == 0)
          m_bvalid_i <= 1'b1;
        else
          b_wait--;
      end
      if (aw_got && w_got)
      begin
        aw_got = 0;
        w_got  = 0;
        b_pend = 1;
        b_wait = $random(seed) & 3;
      end
    end
  end

  task automatic run_ifu();
    logic [7:0] a;
    repeat (N_TX)
    begin
      repeat (1 + ($random(seed) & 3)) @(posedge clk);
      a = $random(seed) & 8'h7c;  // lower half is never written
      ifu_arvalid_i <= 1'b1;
      ifu_araddr_i  <= {24'h0, a};
      do @(posedge clk); while (!ifu_rvalid_o);
      check_word(ifu_rdata_o, model_word(a), "ifu read");
      ifu_arvalid_i <= 1'b0;
    end
  endtask

  task automatic run_lsu();
    int kind;
    int n;
    logic [7:0] a;
    logic [3:0] strb;
    logic [31:0] d;
    logic [63:0] t;
    logic ifu_free;
    logic hi;
    repeat (N_TX)
    begin
      repeat (1 + ($random(seed) & 3)) @(posedge clk);
      kind = $random(seed) & 7;
      n    = ($random(seed) & 3) % 3;
      strb = (n == 0) ? 4'h1 : (n == 1) ? 4'h3 : 4'hf;
      a    = (8'h80 | ($random(seed) & 8'h7f)) & ~((8'd1 << n) - 8'd1);
      d    = $random(seed);
      n    = 0;
      if (kind < 3)
      begin
        lsu_awvalid_i <= 1'b1;
        lsu_awaddr_i  <= {24'h0, a};
        lsu_wdata_i   <= d;
        lsu_wstrb_i   <= strb;
        do @(posedge clk); while (!lsu_wdone_o);
        lsu_awvalid_i <= 1'b0;
        for (int j = 0; j < 4; j++)
          if (strb[j])
            model_mem[a + j] = d[8*j +: 8];
      end
      else if (kind < 6)
      begin
        lsu_arvalid_i <= 1'b1;
        lsu_araddr_i  <= {24'h0, a};
        lsu_rstrb_i   <= strb;
        do @(posedge clk); while (!lsu_rvalid_o);
        check_word(lsu_rdata_o, model_word(a), "lsu load");
        lsu_arvalid_i <= 1'b0;
      end
      else
      begin
        hi       = $random(seed) & 1;
        ifu_free = !ifu_arvalid_i;  // arbiter idle and unlocked
        lsu_arvalid_i <= 1'b1;
        lsu_araddr_i  <= hi ? map_pkg::RTC_ADDR_HI : map_pkg::RTC_ADDR_LO;
        lsu_rstrb_i   <= 4'hf;
        do
        begin
          @(posedge clk);
          n++;
          if (ifu_free && m_arvalid_o)
            stop_with_error("timer read raised arvalid");
        end
        while (!lsu_rvalid_o);
        t = cycle_cnt - 1;  // counter in the req cycle
        if (ifu_free)
          check_word(n - 1, 2, "timer latency");
        check_word(lsu_rdata_o, hi ? t[63:32] : t[31:0], "timer read");
        lsu_arvalid_i <= 1'b0;
      end
    end
  endtask

  initial
  begin
    #(LIMIT_NS);
    $display("timeout: clients did not finish in %0d ns", LIMIT_NS);
    $display("Checks failed");
    $fatal(1);
  end

  initial
  begin
    rst = 1'b1;
    {ifu_arvalid_i, lsu_arvalid_i, lsu_awvalid_i} = '0;
    {ifu_araddr_i, lsu_araddr_i, lsu_awaddr_i, lsu_wdata_i} = '0;
    {lsu_rstrb_i, lsu_wstrb_i} = '0;
    {m_arready_i, m_rvalid_i, m_awready_i, m_wready_i, m_bvalid_i} = '0;
    m_rdata_i = '0;
    m_rresp_i = bus_pkg::RESP_OKAY;
    m_bresp_i = bus_pkg::RESP_OKAY;
    for (int i = 0; i < 256; i++)
    begin
      model_mem[i] = fill_byte(i[7:0]);
      slave_mem[i / 8][8*(i % 8) +: 8] = fill_byte(i[7:0]);
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    fork
      run_ifu();
      run_lsu();
    join
    repeat (4) @(posedge clk);
    $display("All checks passed");
    $finish;
  end

endmodule

//--- files.f
logic/bus_pkg.sv
logic/map_pkg.sv
logic/clint_if.sv
logic/bus_arbiter.sv
logic/lane_align.sv
logic/clint_timer.sv
logic/core_bus_top.sv
verif/core_bus_chk.sv
verif/core_bus_tb.sv

//--- Bender.yml
package:
  name: core_bus

sources:
  - logic/bus_pkg.sv
  - logic/map_pkg.sv
  - logic/clint_if.sv
  - logic/bus_arbiter.sv
  - logic/lane_align.sv
  - logic/clint_timer.sv
  - logic/core_bus_top.sv
  - target: simulation
    files:
      - verif/core_bus_chk.sv
      - verif/core_bus_tb.sv
